//--- common/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and address width
`define CPU_WORD_W 32

// register index width and register count
`define CPU_REG_W 5
`define CPU_NUM_REGS 32

// first fetch address after reset
`define CPU_PC_RESET 32'h0000_0000

// advances from HALT leaving decode until it leaves write-back
`define CPU_DRAIN_DEPTH 3

`endif

//--- common/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

	// major opcodes, halt uses the all-ones encoding
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addiu = 6'h09,
		op_ori   = 6'h0d,
		op_lui   = 6'h0f,
		op_lw    = 6'h23,
		op_sw    = 6'h2b,
		op_halt  = 6'h3f
	} opcode_e;

	// r-type function field
	typedef enum logic [5:0] {
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_slt  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_lui
	} aluop_e;

	// immediate extension kind
	typedef enum logic [1:0] {
		ext_zero,
		ext_sign,
		ext_upper
	} ext_e;

	typedef enum logic [1:0] {
		ctrl_run,
		ctrl_drain,
		ctrl_halted
	} ctrl_state_e;

	// instruction port
	typedef struct packed {
		logic [`CPU_WORD_W-1:0] addr;
		logic                   ren;
	} imem_req_t;

	typedef struct packed {
		logic [`CPU_WORD_W-1:0] load;
		logic                   hit;
	} imem_rsp_t;

	// data port
	typedef struct packed {
		logic [`CPU_WORD_W-1:0] addr;
		logic [`CPU_WORD_W-1:0] wdata;
		logic                   ren;
		logic                   wen;
	} dmem_req_t;

	typedef struct packed {
		logic [`CPU_WORD_W-1:0] rdata;
		logic                   hit;
	} dmem_rsp_t;

	// decoded control, all zero is a bubble
	typedef struct packed {
		aluop_e aluop;
		logic   alu_src;
		ext_e   ext_kind;
		logic   reg_wr;
		logic   mem_rd;
		logic   mem_wr;
		logic   branch_eq;
		logic   branch_ne;
		logic   is_halt;
	} ctrl_t;

	typedef struct packed {
		ctrl_t                  ctrl;
		logic [`CPU_WORD_W-1:0] pc;
		logic [`CPU_WORD_W-1:0] rs_val;
		logic [`CPU_WORD_W-1:0] rt_val;
		logic [`CPU_WORD_W-1:0] imm;
		logic [`CPU_REG_W-1:0]  rs;
		logic [`CPU_REG_W-1:0]  rt;
		logic [`CPU_REG_W-1:0]  dest;
	} id_ex_t;

	typedef struct packed {
		logic                   reg_wr;
		logic                   mem_rd;
		logic                   mem_wr;
		logic [`CPU_WORD_W-1:0] result;
		logic [`CPU_WORD_W-1:0] wdata;
		logic [`CPU_REG_W-1:0]  dest;
		logic                   is_halt;
	} ex_mem_t;

	typedef struct packed {
		logic                   reg_wr;
		logic [`CPU_REG_W-1:0]  dest;
		logic [`CPU_WORD_W-1:0] result;
		logic                   halt;
	} mem_wb_t;

	// one forwarding source seen by execute
	typedef struct packed {
		logic                   valid;
		logic [`CPU_REG_W-1:0]  dest;
		logic [`CPU_WORD_W-1:0] value;
	} fwd_src_t;

endpackage

//--- source/pc_counter.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module pc_counter (
	input  logic                   CLK,
	input  logic                   nRST,
	input  logic                   advance,
	input  logic                   stall_id,
	input  logic                   take_branch,
	input  logic [`CPU_WORD_W-1:0] branch_target,
	output logic [`CPU_WORD_W-1:0] pc
);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pc <= `CPU_PC_RESET;
		end else if (advance) begin
			// redirect wins over the load-use hold
			if (take_branch) begin
				pc <= branch_target;
			end else if (!stall_id) begin
				// next word
				pc <= pc + `CPU_WORD_W'(4);
			end
		end
	end

endmodule

//--- source/pipeline_ctrl.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module pipeline_ctrl (
	input  logic                  CLK,
	input  logic                  nRST,
	input  cpu_pkg::imem_rsp_t    imem_rsp,
	input  cpu_pkg::dmem_req_t    dmem_req,
	input  cpu_pkg::dmem_rsp_t    dmem_rsp,
	input  logic [`CPU_REG_W-1:0] id_rs,
	input  logic [`CPU_REG_W-1:0] id_rt,
	input  logic                  id_is_halt,
	input  cpu_pkg::id_ex_t       ex_stage,
	input  logic                  take_branch,
	output logic                  advance,
	output logic                  stall_id,
	output logic                  flush,
	output logic                  fetch_en,
	output logic                  halt
);

	localparam int CNT_W = $clog2(`CPU_DRAIN_DEPTH + 1);

	cpu_pkg::ctrl_state_e state;
	cpu_pkg::ctrl_state_e state_next;
	logic [CNT_W-1:0]     drain_cnt;
	logic [CNT_W-1:0]     cnt_next;
	logic                 imem_done;
	logic                 dmem_done;
	logic                 halt_leaves_id;

	// fetch stops once halt sits in decode
	assign fetch_en = (state == cpu_pkg::ctrl_run) && !id_is_halt;

	// each port either idle or answered this cycle
	assign imem_done = !fetch_en || imem_rsp.hit;
	assign dmem_done = !(dmem_req.ren || dmem_req.wen) || dmem_rsp.hit;
	assign advance   = imem_done && dmem_done;

	// load in execute feeding decode, r0 never counts
	assign stall_id = ex_stage.ctrl.mem_rd && (ex_stage.dest != '0) &&
		((ex_stage.dest == id_rs) || (ex_stage.dest == id_rt));

	// taken branch kills the two younger stages
	assign flush = take_branch;

	assign halt = (state == cpu_pkg::ctrl_halted);

	// halt moves on to execute this advance
	assign halt_leaves_id = advance && id_is_halt && !flush && !stall_id;

	always_comb begin
		state_next = state;
		cnt_next   = drain_cnt;
		case (state)
			cpu_pkg::ctrl_run: begin
				if (halt_leaves_id) begin
					state_next = cpu_pkg::ctrl_drain;
					cnt_next   = '0;
				end
			end
			cpu_pkg::ctrl_drain: begin
				// last advance carries halt out of write-back
				if (advance) begin
					if (drain_cnt == CNT_W'(`CPU_DRAIN_DEPTH - 1)) begin
						state_next = cpu_pkg::ctrl_halted;
					end else begin
						cnt_next = drain_cnt + 1'b1;
					end
				end
			end
			cpu_pkg::ctrl_halted: begin
				// sticky until reset
				state_next = cpu_pkg::ctrl_halted;
			end
			default: state_next = cpu_pkg::ctrl_run;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state     <= cpu_pkg::ctrl_run;
			drain_cnt <= '0;
		end else begin
			state     <= state_next;
			drain_cnt <= cnt_next;
		end
	end

endmodule

//--- pipeline/decode_stage.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module decode_stage (
	input  logic                   CLK,
	input  logic                   nRST,
	input  logic                   advance,
	input  logic                   stall_id,
	input  logic                   flush,
	input  logic [`CPU_WORD_W-1:0] pc,
	input  cpu_pkg::imem_rsp_t     imem_rsp,
	input  cpu_pkg::mem_wb_t       wb,
	output logic [`CPU_REG_W-1:0]  id_rs,
	output logic [`CPU_REG_W-1:0]  id_rt,
	output logic                   id_is_halt,
	output cpu_pkg::id_ex_t        ex_stage
);

	// if/id register
	logic                   ifid_valid;
	logic [`CPU_WORD_W-1:0] ifid_pc;
	logic [`CPU_WORD_W-1:0] ifid_instr;
	// set once halt has gone past decode
	logic                   halt_seen;

	logic [`CPU_WORD_W-1:0] regs [`CPU_NUM_REGS];

	cpu_pkg::opcode_e       opcode;
	cpu_pkg::funct_e        funct;
	logic [`CPU_REG_W-1:0]  rs;
	logic [`CPU_REG_W-1:0]  rt;
	logic [`CPU_REG_W-1:0]  rd;
	logic [15:0]            imm16;
	cpu_pkg::ctrl_t         ctrl;
	logic [`CPU_REG_W-1:0]  dest;
	logic [`CPU_WORD_W-1:0] imm_ext;
	logic [`CPU_WORD_W-1:0] rs_val;
	logic [`CPU_WORD_W-1:0] rt_val;
	cpu_pkg::id_ex_t        id_next;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			ifid_valid <= 1'b0;
			halt_seen  <= 1'b0;
		end else if (advance) begin
			if (flush) begin
				ifid_valid <= 1'b0;
			end else if (!stall_id) begin
				// nothing fetched behind a halt
				ifid_valid <= !(halt_seen || ctrl.is_halt);
				halt_seen  <= halt_seen || ctrl.is_halt;
			end
		end
	end

	// instruction word and its address
	always_ff @(posedge CLK) begin
		if (advance && !stall_id) begin
			ifid_pc    <= pc;
			ifid_instr <= imem_rsp.load;
		end
	end

	// instruction fields
	assign opcode = cpu_pkg::opcode_e'(ifid_instr[31:26]);
	assign funct  = cpu_pkg::funct_e'(ifid_instr[5:0]);
	assign rs     = ifid_instr[25:21];
	assign rt     = ifid_instr[20:16];
	assign rd     = ifid_instr[15:11];
	assign imm16  = ifid_instr[15:0];

	always_comb begin
		ctrl          = '0;
		ctrl.aluop    = cpu_pkg::alu_add;
		ctrl.ext_kind = cpu_pkg::ext_sign;
		dest          = rt;
		if (ifid_valid) begin
			case (opcode)
				cpu_pkg::op_rtype: begin
					dest        = rd;
					ctrl.reg_wr = 1'b1;
					case (funct)
						cpu_pkg::fn_addu: ctrl.aluop = cpu_pkg::alu_add;
						cpu_pkg::fn_subu: ctrl.aluop = cpu_pkg::alu_sub;
						cpu_pkg::fn_and:  ctrl.aluop = cpu_pkg::alu_and;
						cpu_pkg::fn_or:   ctrl.aluop = cpu_pkg::alu_or;
						cpu_pkg::fn_slt:  ctrl.aluop = cpu_pkg::alu_slt;
						// unknown function acts as a nop
						default: ctrl.reg_wr = 1'b0;
					endcase
				end
				cpu_pkg::op_addiu: begin
					ctrl.reg_wr  = 1'b1;
					ctrl.alu_src = 1'b1;
				end
				cpu_pkg::op_ori: begin
					ctrl.reg_wr   = 1'b1;
					ctrl.alu_src  = 1'b1;
					ctrl.aluop    = cpu_pkg::alu_or;
					ctrl.ext_kind = cpu_pkg::ext_zero;
				end
				cpu_pkg::op_lui: begin
					ctrl.reg_wr   = 1'b1;
					ctrl.alu_src  = 1'b1;
					ctrl.aluop    = cpu_pkg::alu_lui;
					ctrl.ext_kind = cpu_pkg::ext_upper;
				end
				cpu_pkg::op_lw: begin
					ctrl.reg_wr  = 1'b1;
					ctrl.alu_src = 1'b1;
					ctrl.mem_rd  = 1'b1;
				end
				cpu_pkg::op_sw: begin
					ctrl.alu_src = 1'b1;
					ctrl.mem_wr  = 1'b1;
				end
				cpu_pkg::op_beq: ctrl.branch_eq = 1'b1;
				cpu_pkg::op_bne: ctrl.branch_ne = 1'b1;
				cpu_pkg::op_halt: ctrl.is_halt = 1'b1;
				default: ctrl = ctrl;
			endcase
		end
	end

	always_comb begin
		case (ctrl.ext_kind)
			cpu_pkg::ext_zero:  imm_ext = {16'h0000, imm16};
			cpu_pkg::ext_upper: imm_ext = {imm16, 16'h0000};
			default:            imm_ext = {{16{imm16[15]}}, imm16};
		endcase
	end

	// register file, written at the advance that retires wb
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (advance && wb.reg_wr && (wb.dest != '0)) begin
			regs[wb.dest] <= wb.result;
		end
	end

	// reads see a same-cycle write, r0 reads zero
	always_comb begin
		rs_val = regs[rs];
		rt_val = regs[rt];
		if (rs == '0) begin
			rs_val = '0;
		end else if (wb.reg_wr && (wb.dest == rs)) begin
			rs_val = wb.result;
		end
		if (rt == '0) begin
			rt_val = '0;
		end else if (wb.reg_wr && (wb.dest == rt)) begin
			rt_val = wb.result;
		end
	end

	// bubbles present r0 so the hazard check stays quiet
	assign id_rs      = ifid_valid ? rs : '0;
	assign id_rt      = ifid_valid ? rt : '0;
	assign id_is_halt = ctrl.is_halt;

	always_comb begin
		id_next.ctrl   = ctrl;
		id_next.pc     = ifid_pc;
		id_next.rs_val = rs_val;
		id_next.rt_val = rt_val;
		id_next.imm    = imm_ext;
		id_next.rs     = id_rs;
		id_next.rt     = id_rt;
		id_next.dest   = dest;
	end

	// id/ex register, bubble on load-use stall or branch flush
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			ex_stage <= '0;
		end else if (advance) begin
			if (flush || stall_id) begin
				ex_stage <= '0;
			end else begin
				ex_stage <= id_next;
			end
		end
	end

endmodule

//--- pipeline/execute_stage.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module execute_stage (
	input  logic                   CLK,
	input  logic                   nRST,
	input  logic                   advance,
	input  cpu_pkg::id_ex_t        ex_stage,
	input  cpu_pkg::fwd_src_t      mem_fwd,
	input  cpu_pkg::fwd_src_t      wb_fwd,
	output logic                   take_branch,
	output logic [`CPU_WORD_W-1:0] branch_target,
	output cpu_pkg::ex_mem_t       mem_stage
);

	logic [`CPU_WORD_W-1:0] op_a;
	logic [`CPU_WORD_W-1:0] op_b;
	logic [`CPU_WORD_W-1:0] alu_b;
	logic [`CPU_WORD_W-1:0] alu_out;
	logic                   slt_bit;
	cpu_pkg::ex_mem_t       mem_next;

	// newest producer first, then register value
	function automatic logic [`CPU_WORD_W-1:0] pick_operand(
		input logic [`CPU_REG_W-1:0]  idx,
		input logic [`CPU_WORD_W-1:0] reg_val,
		input cpu_pkg::fwd_src_t      near_src,
		input cpu_pkg::fwd_src_t      far_src
	);
		if (idx == '0) begin
			return reg_val;
		end else if (near_src.valid && (near_src.dest == idx)) begin
			return near_src.value;
		end else if (far_src.valid && (far_src.dest == idx)) begin
			return far_src.value;
		end
		return reg_val;
	endfunction

	assign op_a = pick_operand(ex_stage.rs, ex_stage.rs_val, mem_fwd, wb_fwd);
	assign op_b = pick_operand(ex_stage.rt, ex_stage.rt_val, mem_fwd, wb_fwd);

	// immediate or rt as second alu input
	assign alu_b = ex_stage.ctrl.alu_src ? ex_stage.imm : op_b;

	// signed compare
	assign slt_bit = $signed(op_a) < $signed(alu_b);

	always_comb begin
		case (ex_stage.ctrl.aluop)
			cpu_pkg::alu_add: alu_out = op_a + alu_b;
			cpu_pkg::alu_sub: alu_out = op_a - alu_b;
			cpu_pkg::alu_and: alu_out = op_a & alu_b;
			cpu_pkg::alu_or:  alu_out = op_a | alu_b;
			cpu_pkg::alu_slt: alu_out = {{(`CPU_WORD_W-1){1'b0}}, slt_bit};
			// upper extension already placed the halfword
			cpu_pkg::alu_lui: alu_out = alu_b;
			default:          alu_out = op_a + alu_b;
		endcase
	end

	// branch compare on forwarded registers
	assign take_branch = (ex_stage.ctrl.branch_eq && (op_a == op_b)) ||
		(ex_stage.ctrl.branch_ne && (op_a != op_b));

	// pc plus one word plus word offset
	assign branch_target = ex_stage.pc + `CPU_WORD_W'(4) +
		{ex_stage.imm[`CPU_WORD_W-3:0], 2'b00};

	always_comb begin
		mem_next.reg_wr  = ex_stage.ctrl.reg_wr;
		mem_next.mem_rd  = ex_stage.ctrl.mem_rd;
		mem_next.mem_wr  = ex_stage.ctrl.mem_wr;
		mem_next.result  = alu_out;
		// store data takes the forwarded rt
		mem_next.wdata   = op_b;
		mem_next.dest    = ex_stage.dest;
		mem_next.is_halt = ex_stage.ctrl.is_halt;
	end

	// ex/mem register
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			mem_stage <= '0;
		end else if (advance) begin
			mem_stage <= mem_next;
		end
	end

endmodule

//--- pipeline/memwb_stage.sv
`timescale 1ns/10ps

module memwb_stage (
	input  logic               CLK,
	input  logic               nRST,
	input  logic               advance,
	input  cpu_pkg::ex_mem_t   mem_stage,
	input  cpu_pkg::dmem_rsp_t dmem_rsp,
	output cpu_pkg::dmem_req_t dmem_req,
	output cpu_pkg::fwd_src_t  mem_fwd,
	output cpu_pkg::fwd_src_t  wb_fwd,
	output cpu_pkg::mem_wb_t   wb
);

	cpu_pkg::mem_wb_t wb_next;

	// request held by ex/mem until the hit lets the pipe advance
	assign dmem_req = '{
		addr:  mem_stage.result,
		wdata: mem_stage.wdata,
		ren:   mem_stage.mem_rd,
		wen:   mem_stage.mem_wr
	};

	// load value unknown here
	assign mem_fwd = '{
		valid: mem_stage.reg_wr && !mem_stage.mem_rd,
		dest:  mem_stage.dest,
		value: mem_stage.result
	};

	// load data is valid in the advancing cycle
	always_comb begin
		wb_next.reg_wr = mem_stage.reg_wr;
		wb_next.dest   = mem_stage.dest;
		wb_next.result = mem_stage.mem_rd ? dmem_rsp.rdata : mem_stage.result;
		wb_next.halt   = mem_stage.is_halt;
	end

	// mem/wb register
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wb <= '0;
		end else if (advance) begin
			wb <= wb_next;
		end
	end

	assign wb_fwd = '{valid: wb.reg_wr, dest: wb.dest, value: wb.result};

endmodule

//--- source/cpu_top.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_top (
	input  logic                CLK,
	input  logic                nRST,
	output cpu_pkg::imem_req_t  imem_req,
	input  cpu_pkg::imem_rsp_t  imem_rsp,
	output cpu_pkg::dmem_req_t  dmem_req,
	input  cpu_pkg::dmem_rsp_t  dmem_rsp,
	output logic                halt
);

	// controller outputs
	logic advance;
	logic stall_id;
	logic flush;
	logic fetch_en;

	// fetch
	logic [`CPU_WORD_W-1:0] pc;

	// decode to controller
	logic [`CPU_REG_W-1:0] id_rs;
	logic [`CPU_REG_W-1:0] id_rt;
	logic                  id_is_halt;

	// branch resolution from execute
	logic                   take_branch;
	logic [`CPU_WORD_W-1:0] branch_target;

	// stage records
	cpu_pkg::id_ex_t   ex_stage;
	cpu_pkg::ex_mem_t  mem_stage;
	cpu_pkg::mem_wb_t  wb;
	cpu_pkg::fwd_src_t mem_fwd;
	cpu_pkg::fwd_src_t wb_fwd;

	// fetch request straight from the pc
	assign imem_req = '{addr: pc, ren: fetch_en};

	pc_counter u_pc (
		.CLK(CLK), .nRST(nRST),
		.advance(advance), .stall_id(stall_id),
		.take_branch(take_branch), .branch_target(branch_target),
		.pc(pc)
	);

	pipeline_ctrl u_ctrl (
		.CLK(CLK), .nRST(nRST),
		.imem_rsp(imem_rsp), .dmem_req(dmem_req), .dmem_rsp(dmem_rsp),
		.id_rs(id_rs), .id_rt(id_rt), .id_is_halt(id_is_halt),
		.ex_stage(ex_stage), .take_branch(take_branch),
		.advance(advance), .stall_id(stall_id), .flush(flush),
		.fetch_en(fetch_en), .halt(halt)
	);

	decode_stage u_decode (
		.CLK(CLK), .nRST(nRST),
		.advance(advance), .stall_id(stall_id), .flush(flush),
		.pc(pc), .imem_rsp(imem_rsp), .wb(wb),
		.id_rs(id_rs), .id_rt(id_rt), .id_is_halt(id_is_halt),
		.ex_stage(ex_stage)
	);

	execute_stage u_execute (
		.CLK(CLK), .nRST(nRST), .advance(advance),
		.ex_stage(ex_stage), .mem_fwd(mem_fwd), .wb_fwd(wb_fwd),
		.take_branch(take_branch), .branch_target(branch_target),
		.mem_stage(mem_stage)
	);

	memwb_stage u_memwb (
		.CLK(CLK), .nRST(nRST), .advance(advance),
		.mem_stage(mem_stage), .dmem_rsp(dmem_rsp),
		.dmem_req(dmem_req), .mem_fwd(mem_fwd), .wb_fwd(wb_fwd),
		.wb(wb)
	);

endmodule

//--- tests/cpu_checker.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_checker #(
	parameter int MAX_EXP = 64
) (
	input  logic                   CLK,
	input  logic                   nRST,
	input  cpu_pkg::imem_req_t     imem_req,
	input  cpu_pkg::imem_rsp_t     imem_rsp,
	input  cpu_pkg::dmem_req_t     dmem_req,
	input  cpu_pkg::dmem_rsp_t     dmem_rsp,
	input  logic                   halt,
	input  logic [`CPU_WORD_W-1:0] exp_addr [MAX_EXP],
	input  logic [`CPU_WORD_W-1:0] exp_data [MAX_EXP],
	input  int                     exp_count,
	input  logic                   run_done,
	output int                     errors,
	output int                     stores
);

	logic count_checked;
	logic store_done;

	initial begin
		errors        = 0;
		stores        = 0;
		count_checked = 1'b0;
	end

	// store retires only when the fetch port is idle or answered too
	// an earlier hit under a pending fetch repeats the same access
	assign store_done = dmem_req.wen && dmem_rsp.hit && (!imem_req.ren || imem_rsp.hit);

	always @(posedge CLK) begin
		if (nRST && store_done) begin
			if (halt) begin
				$display("store to %h seen after halt", dmem_req.addr);
				errors++;
			end else if (stores >= exp_count) begin
				$display("unexpected extra store %h to %h", dmem_req.wdata, dmem_req.addr);
				errors++;
			end else if (dmem_req.addr != exp_addr[stores] ||
				dmem_req.wdata != exp_data[stores]) begin
				$display("[ERROR] %0t: store %0d expected %h at %h, got %h at %h", $time,
					stores, exp_data[stores], exp_addr[stores], dmem_req.wdata,
					dmem_req.addr);
				errors++;
			end
			stores++;
		end
		// total count must match at the end of the run
		if (run_done && !count_checked) begin
			count_checked = 1'b1;
			if (stores != exp_count) begin
				$display("store count wrong: expected %0d stores, saw %0d", exp_count, stores);
				errors++;
			end
		end
	end

endmodule

//--- tests/cpu_asserts.sv
`timescale 1ns/10ps

module cpu_asserts (
	input logic               CLK,
	input logic               nRST,
	input cpu_pkg::imem_req_t imem_req,
	input cpu_pkg::imem_rsp_t imem_rsp,
	input cpu_pkg::dmem_req_t dmem_req,
	input cpu_pkg::dmem_rsp_t dmem_rsp,
	input logic               halt
);

	int fails = 0;

	// pending fetch unchanged until hit
	imem_hold: assert property (@(posedge CLK) disable iff (!nRST)
		(imem_req.ren && !imem_rsp.hit) |=> $stable(imem_req))
		else begin $error("imem request changed before hit"); fails++; end

	dmem_hold: assert property (@(posedge CLK) disable iff (!nRST)
		((dmem_req.ren || dmem_req.wen) && !dmem_rsp.hit) |=> $stable(dmem_req))
		else begin $error("dmem request changed before hit"); fails++; end

	dmem_one_op: assert property (@(posedge CLK) disable iff (!nRST)
		!(dmem_req.ren && dmem_req.wen))
		else begin $error("dmem ren and wen both set"); fails++; end

	// halt is sticky and stops fetch
	halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
		else begin $error("halt dropped"); fails++; end

	halt_no_fetch: assert property (@(posedge CLK) disable iff (!nRST) halt |-> !imem_req.ren)
		else begin $error("fetch after halt"); fails++; end

endmodule

bind cpu_top cpu_asserts u_asserts (.*);

//--- tests/cpu_tb.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_tb;

	localparam int MAX_EXP      = 64;
	localparam int IMEM_WORDS   = 256;
	localparam int HALT_TIMEOUT = 5000;

	logic               CLK;
	logic               nRST;
	cpu_pkg::imem_req_t imem_req;
	cpu_pkg::imem_rsp_t imem_rsp;
	cpu_pkg::dmem_req_t dmem_req;
	cpu_pkg::dmem_rsp_t dmem_rsp;
	logic               halt;

	// program and data images
	logic [`CPU_WORD_W-1:0] imem [IMEM_WORDS];
	logic [`CPU_WORD_W-1:0] dmem [logic [`CPU_WORD_W-1:0]];

	// expected store sequence
	logic [`CPU_WORD_W-1:0] exp_addr [MAX_EXP];
	logic [`CPU_WORD_W-1:0] exp_data [MAX_EXP];
	int                     exp_count;

	logic        run_done;
	int          chk_errors;
	int          store_count;
	int          tb_errors;
	logic [15:0] lfsr;

	// per-port delay state
	logic i_busy;
	int   i_wait;
	logic d_busy;
	int   d_wait;

	cpu_top u_dut (
		.CLK(CLK), .nRST(nRST),
		.imem_req(imem_req), .imem_rsp(imem_rsp),
		.dmem_req(dmem_req), .dmem_rsp(dmem_rsp),
		.halt(halt)
	);

	cpu_checker #(.MAX_EXP(MAX_EXP)) u_chk (
		.CLK(CLK), .nRST(nRST),
		.imem_req(imem_req), .imem_rsp(imem_rsp),
		.dmem_req(dmem_req), .dmem_rsp(dmem_rsp), .halt(halt),
		.exp_addr(exp_addr), .exp_data(exp_data), .exp_count(exp_count),
		.run_done(run_done), .errors(chk_errors), .stores(store_count)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// right-shift galois form with taps 16 14 13 11
	function automatic logic [15:0] next_lfsr(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	// two bits at one step each give 0..3 cycles
	task automatic draw_delay(output int delay);
		logic [1:0] bits;
		for (int b = 0; b < 2; b++) begin
			lfsr    = next_lfsr(lfsr);
			bits[b] = lfsr[0];
		end
		delay = int'(bits);
	endtask

	// unwritten words read back a pattern of their address
	function automatic logic [`CPU_WORD_W-1:0] read_data(input logic [`CPU_WORD_W-1:0] addr);
		if (dmem.exists(addr)) begin
			return dmem[addr];
		end
		return addr ^ 32'h5a5a_0f0f;
	endfunction

	function automatic logic [`CPU_WORD_W-1:0] fetch_word(input logic [`CPU_WORD_W-1:0] addr);
		if (addr[`CPU_WORD_W-1:10] != '0) begin
			return '0;
		end
		return imem[addr[9:2]];
	endfunction

	// I/D lines fill memories and S lines queue expected stores
	task automatic load_program();
		int                     fd;
		int                     n;
		byte                    tag;
		logic [`CPU_WORD_W-1:0] a;
		logic [`CPU_WORD_W-1:0] d;
		string                  line;
		fd = $fopen("tests/program_input.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/program_input.txt");
			tb_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 0 && line[0] != "#") begin
				n = $sscanf(line, "%c %h %h", tag, a, d);
				if (n == 3 && tag == "I") begin
					imem[a[9:2]] = d;
				end else if (n == 3 && tag == "D") begin
					dmem[a] = d;
				end else if (n == 3 && tag == "S" && exp_count < MAX_EXP) begin
					exp_addr[exp_count] = a;
					exp_data[exp_count] = d;
					exp_count++;
				end
			end
		end
		$fclose(fd);
	endtask

	// both ports answer on the falling edge after a random delay
	always @(negedge CLK) begin
		if (!nRST) begin
			imem_rsp = '0;
			dmem_rsp = '0;
			i_busy   = 1'b0;
			d_busy   = 1'b0;
		end else begin
			// a hit last cycle ends that access
			if (imem_rsp.hit) i_busy = 1'b0;
			if (dmem_rsp.hit) d_busy = 1'b0;
			imem_rsp.hit = 1'b0;
			dmem_rsp.hit = 1'b0;
			if (imem_req.ren) begin
				if (!i_busy) begin
					i_busy = 1'b1;
					draw_delay(i_wait);
				end
				if (i_wait == 0) begin
					imem_rsp.hit  = 1'b1;
					imem_rsp.load = fetch_word(imem_req.addr);
				end else begin
					i_wait--;
				end
			end else begin
				i_busy = 1'b0;
			end
			if (dmem_req.ren || dmem_req.wen) begin
				if (!d_busy) begin
					d_busy = 1'b1;
					draw_delay(d_wait);
				end
				if (d_wait == 0) begin
					dmem_rsp.hit   = 1'b1;
					dmem_rsp.rdata = read_data(dmem_req.addr);
					if (dmem_req.wen) dmem[dmem_req.addr] = dmem_req.wdata;
				end else begin
					d_wait--;
				end
			end else begin
				d_busy = 1'b0;
			end
		end
	end

	initial begin
		int cycles;
		nRST      = 1'b0;
		imem_rsp  = '0;
		dmem_rsp  = '0;
		run_done  = 1'b0;
		tb_errors = 0;
		exp_count = 0;
		lfsr      = 16'd72;
		i_busy    = 1'b0;
		d_busy    = 1'b0;
		i_wait    = 0;
		d_wait    = 0;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = '0;
		end
		load_program();
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
		// wait for halt
		cycles = 0;
		while (!halt && cycles < HALT_TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		if (!halt) begin
			$display("timeout: halt did not rise within %0d cycles", HALT_TIMEOUT);
			tb_errors++;
		end else begin
			// quiet period in which no store may follow halt
			repeat (20) @(negedge CLK);
		end
		run_done = 1'b1;
		@(posedge CLK);
		#1;
		tb_errors += u_dut.u_asserts.fails;
		$display("errors: checker %0d, testbench %0d; stores seen %0d of %0d",
			chk_errors, tb_errors, store_count, exp_count);
		if (chk_errors == 0 && tb_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- tests/program_input.txt
# I byte_addr instr_word | D byte_addr data_word | S store_addr store_data (in order)
# dependent alu chain
I 00000000 24010005
I 00000004 24220003
I 00000008 00221821
I 0000000c 00612023
I 00000010 00832824
I 00000014 00a13025
I 00000018 0026382a
I 0000001c 34e800f0
I 00000020 3c091234
I 00000024 ac030100
I 00000028 ac070104
I 0000002c ac080108
I 00000030 ac09010c
# load then use
I 00000034 8c0a0200
I 00000038 01425821
I 0000003c ac0b0110
# bne loop three times, then beq not taken
I 00000040 240c0003
I 00000044 258cffff
I 00000048 ac0c0120
I 0000004c 1580fffd
I 00000050 240d0007
I 00000054 ac0d0130
I 00000058 118d0002
I 0000005c ac010140
I 00000060 fc000000
D 00000200 11111111
S 00000100 0000000d
S 00000104 00000001
S 00000108 000000f1
S 0000010c 12340000
S 00000110 11111119
S 00000120 00000002
S 00000120 00000001
S 00000120 00000000
S 00000130 00000007
S 00000140 00000005

//--- sim.f
+incdir+common
common/cpu_pkg.sv
source/pc_counter.sv
source/pipeline_ctrl.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
pipeline/memwb_stage.sv
source/cpu_top.sv
tests/cpu_checker.sv
tests/cpu_asserts.sv
tests/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cpu_tb
FILELIST  ?= sim.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
